/* build.f */
+incdir+common
common/cpuPkg.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/datapath.sv
control/microstore.sv
control/microSequencer.sv
src/cpuTop.sv
sim/cpuTb.sv

/* common/cpuPkg.sv */
`include "cpu_macros.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] regIdx_t;

    // data-processing opcode values plus two internal ops on spare codes
    typedef enum logic [3:0] {
        OP_AND   = 4'd0,
        OP_EOR   = 4'd1,
        OP_SUB   = 4'd2,
        OP_RSB   = 4'd3,
        OP_ADD   = 4'd4,
        OP_ORR   = 4'd12,
        OP_MOV   = 4'd13,
        OP_PASSA = 4'd14,
        OP_INC4  = 4'd15
    } aluOp_t;

    typedef enum logic [3:0] {
        FETCH0, FETCH1, DECODE, DPREG, DPIMM, MEMADDR,
        LOADWAIT, LOADWB, STOREDATA, STOREWAIT, HALT
    } microState_t;

    typedef enum logic [1:0] {SEQ, DISPATCH, WAITACK, STOP} nextSel_t;
    typedef enum logic [1:0] {A_RN, A_RD, A_PC} aSel_t;
    typedef enum logic [1:0] {B_REG, B_IMM8, B_OFF12, B_MDR} bSel_t;

    typedef struct packed {
        logic        regWrite;
        logic        irLoad;
        logic        marLoad;
        logic        mdrLoad;
        logic        mdrFromBus;
        logic        busReq;
        logic        busWrite;
        aSel_t       aSel;
        bSel_t       bSel;
        aluOp_t      aluOpSel;
        logic        useInstrOp;
        logic        cSelPc;
        nextSel_t    nextSel;
        microState_t target;
    } microWord_t;

endpackage

/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and address width
`define CPU_XLEN 32

// register file size
`define CPU_NREGS 16

// R15 doubles as the program counter
`define CPU_PC_REG 15

// bytes per instruction word fetched
`define CPU_PC_STEP 4

// opcode field in bits 24:21
`define CPU_OPC_LSB 21

// base or first operand register in bits 19:16
`define CPU_RN_LSB 16

// destination register in bits 15:12
`define CPU_RD_LSB 12

`endif

/* control/microSequencer.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module microSequencer (
    input  logic                Clk,
    input  logic                reset,
    input  cpuPkg::word_t       instr,
    input  logic                Ack,
    input  cpuPkg::nextSel_t    nextSel,
    input  cpuPkg::microState_t target,
    output cpuPkg::microState_t state,
    output logic                Halted
);
    import cpuPkg::*;

    microState_t dispatchState;
    microState_t nextState;
    logic [3:0]  opcode;
    logic        dpOpOk;

    assign opcode = instr[`CPU_OPC_LSB +: 4];

    // supported data-processing opcodes
    always_comb begin
        case (opcode)
            OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ORR, OP_MOV: dpOpOk = 1'b1;
            default: dpOpOk = 1'b0;
        endcase
    end

    // instruction decoder where bit 20 is S for data processing and L for transfers
    always_comb begin
        dispatchState = HALT;
        if (state == MEMADDR) begin
            dispatchState = instr[20] ? LOADWAIT : STOREDATA;
        end else begin
            case (instr[27:25])
                3'b000: begin // register operand without shift
                    if (dpOpOk && !instr[20] && instr[11:4] == 8'h00) begin
                        dispatchState = DPREG;
                    end
                end
                3'b001: begin // immediate without rotation
                    if (dpOpOk && !instr[20] && instr[11:8] == 4'h0) begin
                        dispatchState = DPIMM;
                    end
                end
                3'b010: begin
                    // pre-indexed word access adding the offset without writeback
                    if (instr[24:21] == 4'b1100) begin
                        dispatchState = MEMADDR;
                    end
                end
                default: dispatchState = HALT;
            endcase
        end
    end

    always_comb begin
        case (nextSel)
            SEQ:      nextState = target;
            DISPATCH: nextState = dispatchState;
            WAITACK:  nextState = Ack ? target : state; // hold until the slave answers
            default:  nextState = state;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= FETCH0;
        end else begin
            state <= nextState;
        end
    end

    assign Halted = (state == HALT);

    haltSticky: assert property (@(posedge Clk) disable iff (reset)
        state == HALT |=> state == HALT);

    // decode row of the microstore must hand over to the decoder
    decodeDispatch: assert property (@(posedge Clk) disable iff (reset)
        state == DECODE |-> nextSel == DISPATCH);

endmodule

/* control/microstore.sv */
`timescale 1ns/100ps

module microstore (
    input  cpuPkg::microState_t state,
    output logic                regWrite,
    output logic                irLoad,
    output logic                marLoad,
    output logic                mdrLoad,
    output logic                mdrFromBus,
    output logic                busReq,
    output logic                busWrite,
    output cpuPkg::aSel_t       aSel,
    output cpuPkg::bSel_t       bSel,
    output cpuPkg::aluOp_t      aluOpSel,
    output logic                useInstrOp,
    output logic                cSelPc,
    output cpuPkg::nextSel_t    nextSel,
    output cpuPkg::microState_t target
);
    import cpuPkg::*;

    microWord_t mw;

    // one control word per microstate, unlisted fields stay inactive
    always_comb begin
        mw = '0;
        case (state)
            FETCH0: begin
                mw.aSel     = A_PC;
                mw.aluOpSel = OP_PASSA;
                mw.marLoad  = 1'b1; // MAR <- PC
                mw.target   = FETCH1;
            end
            FETCH1: begin
                mw.busReq   = 1'b1;
                mw.irLoad   = 1'b1;
                mw.aSel     = A_PC;
                mw.aluOpSel = OP_INC4;
                mw.regWrite = 1'b1;
                mw.cSelPc   = 1'b1; // PC <- PC + 4 once Ack arrives
                mw.nextSel  = WAITACK;
                mw.target   = DECODE;
            end
            DECODE: begin
                mw.nextSel = DISPATCH;
            end
            DPREG, DPIMM: begin
                mw.aSel       = A_RN;
                mw.bSel       = (state == DPIMM) ? B_IMM8 : B_REG;
                mw.useInstrOp = 1'b1;
                mw.regWrite   = 1'b1;
                mw.target     = FETCH0;
            end
            MEMADDR: begin
                mw.aSel     = A_RN;
                mw.bSel     = B_OFF12;
                mw.aluOpSel = OP_ADD;
                mw.marLoad  = 1'b1;
                mw.nextSel  = DISPATCH; // load or store picked from L
            end
            LOADWAIT: begin
                mw.busReq     = 1'b1;
                mw.mdrLoad    = 1'b1;
                mw.mdrFromBus = 1'b1;
                mw.nextSel    = WAITACK;
                mw.target     = LOADWB;
            end
            LOADWB: begin
                mw.bSel     = B_MDR;
                mw.aluOpSel = OP_MOV;
                mw.regWrite = 1'b1;
                mw.target   = FETCH0;
            end
            STOREDATA: begin
                mw.mdrLoad = 1'b1; // Rd through port B
                mw.target  = STOREWAIT;
            end
            STOREWAIT: begin
                mw.busReq   = 1'b1;
                mw.busWrite = 1'b1;
                mw.nextSel  = WAITACK;
                mw.target   = FETCH0;
            end
            HALT: begin
                mw.nextSel = STOP;
                mw.target  = HALT;
            end
            default: mw.target = HALT; // unused encodings fall into halt
        endcase
    end

    assign regWrite   = mw.regWrite;
    assign irLoad     = mw.irLoad;
    assign marLoad    = mw.marLoad;
    assign mdrLoad    = mw.mdrLoad;
    assign mdrFromBus = mw.mdrFromBus;
    assign busReq     = mw.busReq;
    assign busWrite   = mw.busWrite;
    assign aSel       = mw.aSel;
    assign bSel       = mw.bSel;
    assign aluOpSel   = mw.aluOpSel;
    assign useInstrOp = mw.useInstrOp;
    assign cSelPc     = mw.cSelPc;
    assign nextSel    = mw.nextSel;
    assign target     = mw.target;

endmodule

/* datapath/alu.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    // all arithmetic wraps at the word width
    always_comb begin
        case (op)
            OP_AND:   result = a & b;
            OP_EOR:   result = a ^ b;
            OP_SUB:   result = a - b;
            OP_RSB:   result = b - a;   // reverse subtract
            OP_ADD:   result = a + b;
            OP_ORR:   result = a | b;
            OP_MOV:   result = b;
            OP_PASSA: result = a;       // PC to MAR
            OP_INC4:  result = a + word_t'(`CPU_PC_STEP);
            default:  result = '0;
        endcase
    end

endmodule

/* datapath/datapath.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module datapath (
    input  logic           Clk,
    input  logic           reset,
    input  logic           regWrite,
    input  logic           irLoad,
    input  logic           marLoad,
    input  logic           mdrLoad,
    input  logic           mdrFromBus,
    input  logic           busReq,
    input  logic           busWrite,
    input  cpuPkg::aSel_t  aSel,
    input  cpuPkg::bSel_t  bSel,
    input  cpuPkg::aluOp_t aluOpSel,
    input  logic           useInstrOp,
    input  logic           cSelPc,
    input  cpuPkg::word_t  DatI,
    input  logic           Ack,
    output cpuPkg::word_t  instr,
    output logic           Cyc,
    output logic           Stb,
    output logic           We,
    output cpuPkg::word_t  Adr,
    output cpuPkg::word_t  DatO
);
    import cpuPkg::*;

    word_t   ir, mar, mdr;
    word_t   portA, portB, aluB, aluResult;
    regIdx_t rn, rd, aIdx, bIdx, cIdx;
    aluOp_t  aluOp;
    logic    writeEn;

    assign rn = instr[`CPU_RN_LSB +: 4];
    assign rd = instr[`CPU_RD_LSB +: 4];

    always_comb begin
        case (aSel)
            A_RN:    aIdx = rn;
            A_RD:    aIdx = rd;
            default: aIdx = regIdx_t'(`CPU_PC_REG);
        endcase
    end

    // store data comes out of port B from Rd, otherwise Rm
    assign bIdx = (mdrLoad && !mdrFromBus) ? rd : instr[3:0];
    assign cIdx = cSelPc ? regIdx_t'(`CPU_PC_REG) : rd;

    always_comb begin
        case (bSel)
            B_REG:   aluB = portB;
            B_IMM8:  aluB = word_t'(instr[7:0]);
            B_OFF12: aluB = word_t'(instr[11:0]);
            default: aluB = mdr;
        endcase
    end

    assign aluOp = useInstrOp ? aluOp_t'(instr[`CPU_OPC_LSB +: 4]) : aluOpSel;

    // writes during a bus cycle wait for the acknowledge
    assign writeEn = regWrite && (!busReq || Ack);

    registerFile uRegFile (
        .Clk       (Clk),
        .reset     (reset),
        .aIdx      (aIdx),
        .bIdx      (bIdx),
        .cIdx      (cIdx),
        .writeEn   (writeEn),
        .writeData (aluResult),
        .portA     (portA),
        .portB     (portB)
    );

    alu uAlu (
        .a      (portA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult)
    );

    always_ff @(posedge Clk) begin
        if (irLoad && Ack) begin
            ir <= DatI;
        end
        if (marLoad) begin
            mar <= aluResult;
        end
        if (mdrLoad && (!mdrFromBus || Ack)) begin
            mdr <= mdrFromBus ? DatI : portB;
        end
    end

    assign instr = ir;
    assign Cyc   = busReq;
    assign Stb   = busReq;
    assign We    = busWrite;
    assign Adr   = mar;
    assign DatO  = mdr;

    stbAligned: assert property (@(posedge Clk) disable iff (reset)
        Stb |-> Cyc && Adr[1:0] == 2'b00);

    // request is held unchanged while the slave stalls
    stbHeld: assert property (@(posedge Clk) disable iff (reset)
        Stb && !Ack |=> Stb && $stable(Adr) && $stable(We) && $stable(DatO));

endmodule

/* datapath/registerFile.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module registerFile (
    input  logic            Clk,
    input  logic            reset,
    input  cpuPkg::regIdx_t aIdx,
    input  cpuPkg::regIdx_t bIdx,
    input  cpuPkg::regIdx_t cIdx,
    input  logic            writeEn,
    input  cpuPkg::word_t   writeData,
    output cpuPkg::word_t   portA,
    output cpuPkg::word_t   portB
);
    import cpuPkg::*;

    word_t regs [`CPU_NREGS];

    // R15 is cleared too, so fetch starts at address 0
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[cIdx] <= writeData;
        end
    end

    assign portA = regs[aIdx]; // read ports see the old value
    assign portB = regs[bIdx];

endmodule

/* run.sh */
#!/bin/sh
# compile and run the CPU regression with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module cpuTb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* sim/cpuTb.sv */
`timescale 1ns/100ps

module cpuTb;

    logic        Clk;
    logic        reset;
    logic        Cyc, Stb, We, Ack, Halted;
    logic [31:0] Adr, DatO, DatI;

    logic [31:0] mem [0:1023];   // 4 KB word memory
    logic [31:0] expWrAdr [$];
    logic [31:0] expWrDat [$];
    logic [31:0] haltAddr;
    logic [31:0] nextFetch;
    logic [31:0] lastFetch;
    logic [31:0] rngState;
    int          progCount;
    logic        stimLoaded;

    cpuTop u_dut (
        .Clk    (Clk),
        .reset  (reset),
        .Cyc    (Cyc),
        .Stb    (Stb),
        .We     (We),
        .Adr    (Adr),
        .DatO   (DatO),
        .DatI   (DatI),
        .Ack    (Ack),
        .Halted (Halted)
    );

    task automatic stopWithFailure;
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            stopWithFailure();
        end
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic loadStimulus;
        int            fd;
        int            got;
        int            i;
        logic [7:0]    tag;
        logic [31:0]   addr;
        logic [31:0]   data;
        logic [1023:0] skipLine;
        for (i = 0; i < 1024; i++) begin
            mem[i] = 32'hc3c30000 ^ (i << 2); // background differs per address
        end
        fd = $fopen("sim/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/cpu_stim.txt");
            stopWithFailure();
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "P": begin
                        got = $fscanf(fd, "%h", data);
                        mem[progCount[9:0]] = data; // program starts at address 0
                        progCount++;
                    end
                    "D": begin
                        got = $fscanf(fd, "%h %h", addr, data);
                        mem[addr[11:2]] = data;
                    end
                    "W": begin
                        got = $fscanf(fd, "%h %h", addr, data);
                        expWrAdr.push_back(addr);
                        expWrDat.push_back(data);
                    end
                    "H": got = $fscanf(fd, "%h", haltAddr);
                    "#": got = $fgets(skipLine, fd); // comment up to end of line
                    default: begin
                        $display("unknown record tag %c in the stimulus file", tag);
                        stopWithFailure();
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    initial begin : clockGen
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Wishbone slave answering each request after 0 to 3 wait cycles
    initial begin : memoryModel
        logic        busy;
        logic        firstDone;
        logic        reqWe;
        logic [31:0] reqAdr;
        logic [31:0] reqDat;
        int          waitLeft;
        Ack = 1'b0;
        DatI = '0;
        busy = 1'b0;
        firstDone = 1'b0;
        waitLeft = 0;
        rngState = 32'h8fffb92d;
        forever begin
            @(posedge Clk);
            if (reset) begin
                Ack <= 1'b0;
                busy = 1'b0;
            end else if (Stb === 1'b1) begin
                compareValue("Cyc", 32'(Cyc), 32'h1); // strobe only inside a cycle
                if (busy) begin
                    compareValue("Adr", Adr, reqAdr); // request must not move while waiting
                    compareValue("We", 32'(We), 32'(reqWe));
                    compareValue("DatO", DatO, reqDat);
                end else begin
                    busy = 1'b1;
                    reqAdr = Adr;
                    reqWe = We;
                    reqDat = DatO;
                    rngState = nextRandom(rngState);
                    waitLeft = int'(rngState[1:0]);
                    if (!firstDone) begin
                        compareValue("first cycle We", 32'(We), 32'h0);
                        compareValue("first cycle Adr", Adr, 32'h0);
                        firstDone = 1'b1;
                    end
                    if (Adr[31:12] != 20'h0) begin
                        $display("bus access to %h lies outside the memory", Adr);
                        stopWithFailure();
                    end
                    if (!We && Adr < progCount * 4) begin
                        compareValue("fetch Adr", Adr, nextFetch); // no branches in the program
                        lastFetch = Adr;
                        nextFetch = nextFetch + 32'd4;
                    end
                end
                if (Ack) begin
                    if (We) begin // write completes on this edge
                        if (expWrAdr.size() == 0) begin
                            $display("unexpected write of %h to address %h", DatO, Adr);
                            stopWithFailure();
                        end else begin
                            compareValue("write Adr", Adr, expWrAdr.pop_front());
                            compareValue("write DatO", DatO, expWrDat.pop_front());
                            mem[Adr[11:2]] = DatO;
                        end
                    end
                    Ack <= 1'b0;
                    busy = 1'b0;
                end else if (waitLeft == 0) begin
                    Ack <= 1'b1;
                    if (!We) begin
                        DatI <= mem[Adr[11:2]];
                    end
                end else begin
                    waitLeft--;
                end
            end else if (busy || Ack) begin
                $display("Stb fell before the request was acknowledged");
                stopWithFailure();
            end
        end
    end

    initial begin : watchdog
        wait (stimLoaded);
        repeat (40 * progCount + 200) @(posedge Clk);
        $display("no halt within %0d cycles", 40 * progCount + 200);
        stopWithFailure();
    end

    initial begin : mainFlow
        reset = 1'b1;
        stimLoaded = 1'b0;
        progCount = 0;
        nextFetch = '0;
        lastFetch = '0;
        haltAddr = '0;
        loadStimulus();
        stimLoaded = 1'b1;
        repeat (3) begin
            @(posedge Clk);
            @(negedge Clk);
            compareValue("Cyc in reset", 32'(Cyc), 32'h0);
            compareValue("Stb in reset", 32'(Stb), 32'h0);
            compareValue("We in reset", 32'(We), 32'h0);
            compareValue("Halted in reset", 32'(Halted), 32'h0);
        end
        @(posedge Clk);
        reset <= 1'b0; // fourth reset edge
        wait (Halted === 1'b1);
        @(negedge Clk);
        compareValue("halt instruction address", lastFetch, haltAddr);
        repeat (20) begin
            @(negedge Clk);
            compareValue("Stb after halt", 32'(Stb), 32'h0);
            compareValue("Cyc after halt", 32'(Cyc), 32'h0);
            compareValue("Halted", 32'(Halted), 32'h1);
        end
        if (expWrAdr.size() != 0) begin
            $display("%0d expected writes never happened", expWrAdr.size());
            stopWithFailure();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* sim/cpu_stim.txt */
# tag P: program word | D: address data preload | W: address data expected write, in order
# tag H: address of the halting instruction | all values hex, text after # is ignored
P e3a0105a # 00 MOV R1, #0x5A
P e3a0200f # 04 MOV R2, #0x0F
P e0813002 # 08 ADD R3, R1, R2 -> 0x69
P e2833017 # 0C ADD R3, R3, #0x17 -> 0x80
P e0434002 # 10 SUB R4, R3, R2 -> 0x71
P e2444010 # 14 SUB R4, R4, #0x10 -> 0x61
P e0645002 # 18 RSB R5, R4, R2 -> 0xFFFFFFAE
P e2655001 # 1C RSB R5, R5, #0x01 -> 0x53
P e0256001 # 20 EOR R6, R5, R1 -> 0x09
P e22660ff # 24 EOR R6, R6, #0xFF -> 0xF6
P e1867002 # 28 ORR R7, R6, R2 -> 0xFF
P e38580a0 # 2C ORR R8, R5, #0xA0 -> 0xF3
P e0089001 # 30 AND R9, R8, R1 -> 0x52
P e209901f # 34 AND R9, R9, #0x1F -> 0x12
P e1a0a007 # 38 MOV R10, R7 -> 0xFF
P e580a200 # 3C STR R10, [R0, #0x200]
P e5809204 # 40 STR R9, [R0, #0x204]
P e5805208 # 44 STR R5, [R0, #0x208]
P e580820c # 48 STR R8, [R0, #0x20C]
P e58161b6 # 4C STR R6, [R1, #0x1B6] base 0x5A
P e590b100 # 50 LDR R11, [R0, #0x100]
P e590c104 # 54 LDR R12, [R0, #0x104]
P e04bd00c # 58 SUB R13, R11, R12 -> 0x21436588
P e580d100 # 5C STR R13, [R0, #0x100]
P e02be00c # 60 EOR R14, R11, R12 -> 0xE2C4A688
P e580e104 # 64 STR R14, [R0, #0x104]
P e5901100 # 68 LDR R1, [R0, #0x100] reads back the stored word
P e2811078 # 6C ADD R1, R1, #0x78 -> 0x21436600
P e5801214 # 70 STR R1, [R0, #0x214]
P ffffffff # 74 undefined, halts
D 00000100 12345678
D 00000104 f0f0f0f0
W 00000200 000000ff
W 00000204 00000012
W 00000208 00000053
W 0000020c 000000f3
W 00000210 000000f6
W 00000100 21436588
W 00000104 e2c4a688
W 00000214 21436600
H 00000074

/* src/cpuTop.sv */
`timescale 1ns/100ps

module cpuTop (
    input  logic          Clk,
    input  logic          reset,
    output logic          Cyc,
    output logic          Stb,
    output logic          We,
    output cpuPkg::word_t Adr,
    output cpuPkg::word_t DatO,
    input  cpuPkg::word_t DatI,
    input  logic          Ack,
    output logic          Halted
);
    import cpuPkg::*;

    microState_t state, target;
    nextSel_t    nextSel;
    aSel_t       aSel;
    bSel_t       bSel;
    aluOp_t      aluOpSel;
    word_t       instr;
    logic        regWrite, irLoad, marLoad, mdrLoad, mdrFromBus;
    logic        busReq, busWrite, useInstrOp, cSelPc;

    microSequencer uSeq (
        .Clk     (Clk),
        .reset   (reset),
        .instr   (instr),
        .Ack     (Ack),
        .nextSel (nextSel),
        .target  (target),
        .state   (state),
        .Halted  (Halted)
    );

    microstore uStore (
        .state      (state),
        .regWrite   (regWrite),
        .irLoad     (irLoad),
        .marLoad    (marLoad),
        .mdrLoad    (mdrLoad),
        .mdrFromBus (mdrFromBus),
        .busReq     (busReq),
        .busWrite   (busWrite),
        .aSel       (aSel),
        .bSel       (bSel),
        .aluOpSel   (aluOpSel),
        .useInstrOp (useInstrOp),
        .cSelPc     (cSelPc),
        .nextSel    (nextSel),
        .target     (target)
    );

    datapath uDatapath (
        .Clk        (Clk),
        .reset      (reset),
        .regWrite   (regWrite),
        .irLoad     (irLoad),
        .marLoad    (marLoad),
        .mdrLoad    (mdrLoad),
        .mdrFromBus (mdrFromBus),
        .busReq     (busReq),
        .busWrite   (busWrite),
        .aSel       (aSel),
        .bSel       (bSel),
        .aluOpSel   (aluOpSel),
        .useInstrOp (useInstrOp),
        .cSelPc     (cSelPc),
        .DatI       (DatI),
        .Ack        (Ack),
        .instr      (instr),
        .Cyc        (Cyc),
        .Stb        (Stb),
        .We         (We),
        .Adr        (Adr),
        .DatO       (DatO)
    );

endmodule
